// ==== Makefile ====
TOP = kb_check_tb

.PHONY: build run clean

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f list.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== design/kb_check_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module kb_check_top #(
    parameter int XTEA_CYCLES = 32
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            stall,
    input  wire logic            start,
    input  wire kb_pkg::digest_t in_buf,
    input  wire kb_pkg::kb_t     kb,
    output kb_pkg::digest_t      key,
    output logic                 valid,
    output logic                 done
);
    import kb_pkg::*;

    logic    write;
    waddr_t  waddr;
    word_t   wdata;
    logic    go_hash;
    logic    hash_done;
    digest_t digest;
    logic    go_dec;
    logic    dec_done;
    digest_t ct;
    digest_t pt;

    key_check_ctrl ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .start     (start),
        .in_buf    (in_buf),
        .kb        (kb),
        .digest    (digest),
        .hash_done (hash_done),
        .pt        (pt),
        .dec_done  (dec_done),
        .write     (write),
        .go_hash   (go_hash),
        .go_dec    (go_dec),
        .waddr     (waddr),
        .wdata     (wdata),
        .ct        (ct),
        .key       (key),
        .valid     (valid),
        .done      (done)
    );

    md5_core md5_i (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .write     (write),
        .waddr     (waddr),
        .wdata     (wdata),
        .go        (go_hash),
        .digest    (digest),
        .hash_done (hash_done)
    );

    // digest goes straight in as the cipher key
    xtea_dec #(
        .XTEA_CYCLES (XTEA_CYCLES)
    ) xtea_i (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .go       (go_dec),
        .ct       (ct),
        .dkey     (digest),
        .pt       (pt),
        .dec_done (dec_done)
    );

endmodule

`default_nettype wire

// ==== design/kb_pkg.sv ====
`default_nettype none

package kb_pkg;

    typedef logic [31:0]  word_t;    // md5 message or state word
    typedef logic [127:0] digest_t;  // digest, cipher key, tag, plaintext
    typedef logic [447:0] kb_t;      // key block candidate
    typedef logic [3:0]   waddr_t;   // message buffer address

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_HASH,
        S_DECRYPT,
        S_REPORT
    } ctrl_state_t;

    // A, B, C, D start values
    localparam word_t MD5_IV [4] = '{32'h67452301, 32'hefcdab89, 32'h98badcfe, 32'h10325476};

    localparam word_t MD5_K [64] = '{
        32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
        32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
        32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
        32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
        32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
        32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
        32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
        32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
        32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
        32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
        32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
        32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
        32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
        32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
        32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
        32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
    };

    localparam word_t XTEA_DELTA = 32'h9e3779b9;

    localparam word_t PAD_WORD14 = 32'h0000_0000;  // no length field
    localparam word_t PAD_WORD15 = 32'h8000_0000;  // trailing one bit

    function automatic word_t md5_k(input logic [5:0] i);
        return MD5_K[i];
    endfunction

    // rotate amount, four per round, cycled by step
    function automatic logic [4:0] md5_s(input logic [5:0] i);
        logic [4:0] s;
        case ({i[5:4], i[1:0]})
            4'h0: s = 5'd7;   4'h1: s = 5'd12;  4'h2: s = 5'd17;  4'h3: s = 5'd22;
            4'h4: s = 5'd5;   4'h5: s = 5'd9;   4'h6: s = 5'd14;  4'h7: s = 5'd20;
            4'h8: s = 5'd4;   4'h9: s = 5'd11;  4'ha: s = 5'd16;  4'hb: s = 5'd23;
            4'hc: s = 5'd6;   4'hd: s = 5'd10;  4'he: s = 5'd15;  default: s = 5'd21;
        endcase
        return s;
    endfunction

endpackage

`default_nettype wire

// ==== design/key_check_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_check_ctrl (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            stall,
    input  wire logic            start,
    input  wire kb_pkg::digest_t in_buf,
    input  wire kb_pkg::kb_t     kb,
    input  wire kb_pkg::digest_t digest,
    input  wire logic            hash_done,
    input  wire kb_pkg::digest_t pt,
    input  wire logic            dec_done,
    output logic                 write,
    output logic                 go_hash,
    output logic                 go_dec,
    output kb_pkg::waddr_t       waddr,
    output kb_pkg::word_t        wdata,
    output kb_pkg::digest_t      ct,
    output kb_pkg::digest_t      key,
    output logic                 valid,
    output logic                 done
);
    import kb_pkg::*;

    ctrl_state_t state;
    logic [4:0]  cnt;       // word counter, bit 4 marks end of load
    kb_t         kb_q;      // candidate held for the whole check
    digest_t     hash_q;
    logic        match;

    // padded block, streamed one word per load cycle
    assign write = (state == S_LOAD) && !cnt[4];
    assign waddr = cnt[3:0];

    always_comb begin
        if (cnt[3:0] == 4'd14) begin
            wdata = PAD_WORD14;
        end else if (cnt[3:0] == 4'd15) begin
            wdata = PAD_WORD15;
        end else begin
            wdata = kb_q[32*cnt[3:0] +: 32];
        end
    end

    assign go_dec = (state == S_HASH) && hash_done;  // same cycle as hash_done
    assign match  = (pt == hash_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_IDLE;
            cnt     <= '0;
            go_hash <= 1'b0;
            valid   <= 1'b0;
            done    <= 1'b0;
            key     <= '0;
        end else if (!stall) begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        valid <= 1'b0;
                        key   <= '0;
                        cnt   <= '0;
                        state <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    if (cnt[4]) begin
                        go_hash <= 1'b1;  // all 16 words written
                        state   <= S_HASH;
                    end else begin
                        cnt <= cnt + 5'd1;
                    end
                end
                S_HASH: begin
                    go_hash <= 1'b0;
                    if (hash_done) begin
                        state <= S_DECRYPT;
                    end
                end
                S_DECRYPT: begin
                    if (dec_done) begin
                        state <= S_REPORT;
                    end
                end
                S_REPORT: begin
                    valid <= match;
                    key   <= match ? hash_q : '0;
                    done  <= 1'b1;
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // payload latches
    always_ff @(posedge clk) begin
        if (!stall) begin
            if (state == S_IDLE && start) begin
                ct   <= in_buf;
                kb_q <= kb;
            end
            if (go_dec) begin
                hash_q <= digest;
            end
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        done && !stall |=> !done)
        else $error("key_check_ctrl: done held longer than one cycle");

    a_go_after_load: assert property (@(posedge clk) disable iff (rst)
        !(go_hash && write))
        else $error("key_check_ctrl: hash started during message load");

endmodule

`default_nettype wire

// ==== design/md5_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module md5_core (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           stall,
    input  wire logic           write,
    input  wire kb_pkg::waddr_t waddr,
    input  wire kb_pkg::word_t  wdata,
    input  wire logic           go,
    output kb_pkg::digest_t     digest,
    output logic                hash_done
);
    import kb_pkg::*;

    word_t msg [16];        // message block buffer

    word_t a_q;
    word_t b_q;
    word_t c_q;
    word_t d_q;

    logic [5:0] step;       // current md5 step 0..63
    logic       busy;       // steps in progress
    logic       fin;        // final IV addition pending

    word_t      f;          // round function result
    waddr_t     g;          // message word index
    word_t      temp;
    word_t      rot;
    logic [4:0] s;

    // message buffer, written word by word by the controller
    always_ff @(posedge clk) begin
        if (write && !stall) begin
            msg[waddr] <= wdata;
        end
    end

    // round function and message schedule for this step
    always_comb begin
        case (step[5:4])
            2'd0: begin
                f = (b_q & c_q) | (~b_q & d_q);
                g = step[3:0];
            end
            2'd1: begin
                f = (d_q & b_q) | (~d_q & c_q);
                g = 4'(step[3:0] * 4'd5 + 4'd1);
            end
            2'd2: begin
                f = b_q ^ c_q ^ d_q;
                g = 4'(step[3:0] * 4'd3 + 4'd5);
            end
            default: begin
                f = c_q ^ (b_q | ~d_q);
                g = 4'(step[3:0] * 4'd7);
            end
        endcase
        s    = md5_s(step);
        temp = a_q + f + md5_k(step) + msg[g];
        rot  = (temp << s) | (temp >> (6'd32 - {1'b0, s}));  // rotate left by s
    end

    // control: go, 64 steps, IV addition
    always_ff @(posedge clk) begin
        if (rst) begin
            step      <= '0;
            busy      <= 1'b0;
            fin       <= 1'b0;
            hash_done <= 1'b0;
        end else if (!stall) begin
            hash_done <= 1'b0;
            if (go) begin
                step <= '0;
                busy <= 1'b1;
            end else if (busy) begin
                step <= step + 6'd1;
                if (step == 6'd63) begin
                    busy <= 1'b0;
                    fin  <= 1'b1;
                end
            end else if (fin) begin
                fin       <= 1'b0;
                hash_done <= 1'b1;  // digest valid from here
            end
        end
    end

    // working state, no reset needed
    always_ff @(posedge clk) begin
        if (!stall) begin
            if (go) begin
                a_q <= MD5_IV[0];
                b_q <= MD5_IV[1];
                c_q <= MD5_IV[2];
                d_q <= MD5_IV[3];
            end else if (busy) begin
                a_q <= d_q;
                b_q <= b_q + rot;
                c_q <= b_q;
                d_q <= c_q;
            end else if (fin) begin
                a_q <= a_q + MD5_IV[0];
                b_q <= b_q + MD5_IV[1];
                c_q <= c_q + MD5_IV[2];
                d_q <= d_q + MD5_IV[3];
            end
        end
    end

    assign digest = {d_q, c_q, b_q, a_q};  // word 0 is A

    // a new block must not start on top of a running one
    a_go_idle: assert property (@(posedge clk) disable iff (rst)
        go |-> !busy && !fin)
        else $error("md5_core: go while compression running");

endmodule

`default_nettype wire

// ==== design/xtea_dec.sv ====
`timescale 1ns/1ps
`default_nettype none

module xtea_dec #(
    parameter int XTEA_CYCLES = 32
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            stall,
    input  wire logic            go,
    input  wire kb_pkg::digest_t ct,
    input  wire kb_pkg::digest_t dkey,
    output kb_pkg::digest_t      pt,
    output logic                 dec_done
);
    import kb_pkg::*;

    localparam word_t SUM_INIT = XTEA_DELTA * XTEA_CYCLES;

    digest_t     key_q;      // key words k0..k3 from low to high
    word_t       sum;        // shared by both lanes
    logic [63:0] lane0;      // {v1, v0} of tag bits 63:0
    logic [63:0] lane1;      // {v1, v0} of tag bits 127:64
    logic [6:0]  cnt;
    logic        busy;

    function automatic word_t mix(input word_t v);
        return ((v << 4) ^ (v >> 5)) + v;
    endfunction

    // one full decryption cycle, both half rounds
    function automatic logic [63:0] dec_cycle(input logic [63:0] v, input word_t sm,
                                              input digest_t k);
        word_t v0;
        word_t v1;
        word_t sm2;
        v0  = v[31:0];
        v1  = v[63:32];
        v1  = v1 - (mix(v0) ^ (sm + k[32*sm[12:11] +: 32]));
        sm2 = sm - XTEA_DELTA;
        v0  = v0 - (mix(v1) ^ (sm2 + k[32*sm2[1:0] +: 32]));
        return {v1, v0};
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt      <= '0;
            busy     <= 1'b0;
            dec_done <= 1'b0;
        end else if (!stall) begin
            dec_done <= 1'b0;
            if (go) begin
                cnt  <= '0;
                busy <= 1'b1;
            end else if (busy) begin
                cnt <= cnt + 7'd1;
                if (cnt == 7'(XTEA_CYCLES - 1)) begin
                    busy     <= 1'b0;
                    dec_done <= 1'b1;  // lands with the last cycle
                end
            end
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        if (!stall) begin
            if (go) begin
                key_q <= dkey;
                sum   <= SUM_INIT;
                lane0 <= ct[63:0];
                lane1 <= ct[127:64];
            end else if (busy) begin
                lane0 <= dec_cycle(lane0, sum, key_q);
                lane1 <= dec_cycle(lane1, sum, key_q);
                sum   <= sum - XTEA_DELTA;
            end
        end
    end

    assign pt = {lane1, lane0};

    a_done_count: assert property (@(posedge clk) disable iff (rst)
        dec_done |-> cnt == 7'(XTEA_CYCLES))
        else $error("xtea_dec: done before all cycles ran");

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+tb
design/kb_pkg.sv
design/md5_core.sv
design/xtea_dec.sv
design/key_check_ctrl.sv
design/kb_check_top.sv
tb/kb_check_tb.sv

// ==== tb/kb_ref_model.svh ====
`ifndef KB_REF_MODEL_SVH
`define KB_REF_MODEL_SVH

function automatic word_t rotl(input word_t x, input logic [4:0] n);
    return (x << n) | (x >> (32 - 32'(n)));
endfunction

// padded block word i: kb words, then zero, then the one bit
function automatic word_t pad_word(input kb_t k, input int i);
    if (i == 14) begin
        return PAD_WORD14;
    end
    if (i == 15) begin
        return PAD_WORD15;
    end
    return k[32*i +: 32];
endfunction

// single block compression from the standard IV
function automatic digest_t md5_model(input kb_t k);
    word_t m [16];
    word_t a;
    word_t b;
    word_t c;
    word_t d;
    word_t f;
    word_t t;
    int    g;
    for (int i = 0; i < 16; i++) begin
        m[i] = pad_word(k, i);
    end
    a = MD5_IV[0];
    b = MD5_IV[1];
    c = MD5_IV[2];
    d = MD5_IV[3];
    for (int i = 0; i < 64; i++) begin
        if (i < 16) begin
            f = (b & c) | (~b & d);
            g = i;
        end else if (i < 32) begin
            f = (d & b) | (~d & c);
            g = (5 * i + 1) % 16;
        end else if (i < 48) begin
            f = b ^ c ^ d;
            g = (3 * i + 5) % 16;
        end else begin
            f = c ^ (b | ~d);
            g = (7 * i) % 16;
        end
        t = d;
        d = c;
        c = b;
        b = b + rotl(a + f + md5_k(6'(i)) + m[g], md5_s(6'(i)));
        a = t;
    end
    return {d + MD5_IV[3], c + MD5_IV[2], b + MD5_IV[1], a + MD5_IV[0]};
endfunction

function automatic word_t key_word(input digest_t k, input logic [1:0] idx);
    return k[32*idx +: 32];
endfunction

function automatic logic [63:0] xtea_enc_block(input logic [63:0] v, input digest_t k,
                                               input int n);
    word_t v0;
    word_t v1;
    word_t sum;
    v0  = v[31:0];
    v1  = v[63:32];
    sum = '0;
    for (int i = 0; i < n; i++) begin
        v0  = v0 + ((((v1 << 4) ^ (v1 >> 5)) + v1) ^ (sum + key_word(k, sum[1:0])));
        sum = sum + XTEA_DELTA;
        v1  = v1 + ((((v0 << 4) ^ (v0 >> 5)) + v0) ^ (sum + key_word(k, sum[12:11])));
    end
    return {v1, v0};
endfunction

function automatic logic [63:0] xtea_dec_block(input logic [63:0] v, input digest_t k,
                                               input int n);
    word_t v0;
    word_t v1;
    word_t sum;
    v0  = v[31:0];
    v1  = v[63:32];
    sum = XTEA_DELTA * n;
    for (int i = 0; i < n; i++) begin
        v1  = v1 - ((((v0 << 4) ^ (v0 >> 5)) + v0) ^ (sum + key_word(k, sum[12:11])));
        sum = sum - XTEA_DELTA;
        v0  = v0 - ((((v1 << 4) ^ (v1 >> 5)) + v1) ^ (sum + key_word(k, sum[1:0])));
    end
    return {v1, v0};
endfunction

// ecb over the two 64-bit halves
function automatic digest_t xtea_encrypt(input digest_t t, input digest_t k, input int n);
    return {xtea_enc_block(t[127:64], k, n), xtea_enc_block(t[63:0], k, n)};
endfunction

function automatic digest_t xtea_decrypt(input digest_t t, input digest_t k, input int n);
    return {xtea_dec_block(t[127:64], k, n), xtea_dec_block(t[63:0], k, n)};
endfunction

`endif

// ==== tb/kb_check_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module kb_check_tb;
    import kb_pkg::*;

    `include "kb_ref_model.svh"

    localparam int XTEA_CYCLES = 32;
    localparam int NUM_ITEMS   = 24;
    localparam int CYCLE_LIMIT = (NUM_ITEMS + 1) * (150 + XTEA_CYCLES) * 2;

    logic    clk;
    logic    rst;
    logic    stall;
    logic    start;
    digest_t in_buf;
    kb_t     kb;
    digest_t key;
    logic    valid;
    logic    done;

    integer  seed;
    int      cycles = 0;
    logic    stall_on;  // random stall levels
    logic    noise_on;  // start pulses and input changes while busy

    kb_check_top #(
        .XTEA_CYCLES (XTEA_CYCLES)
    ) dut_i (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .start  (start),
        .in_buf (in_buf),
        .kb     (kb),
        .key    (key),
        .valid  (valid),
        .done   (done)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the DUT gave no result within %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check(input digest_t got, input digest_t exp, input string what);
        if (got !== exp) begin
            $display("ERR at %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    function automatic kb_t rand_kb();
        kb_t k;
        for (int i = 0; i < 14; i++) begin
            k[32*i +: 32] = rand_word();
        end
        return k;
    endfunction

    function automatic digest_t rand_tag();
        return {rand_word(), rand_word(), rand_word(), rand_word()};
    endfunction

    task automatic drive_stall();
        word_t r;
        r     = rand_word();
        stall = stall_on && (r[1:0] == 2'b00);  // about one cycle in four
    endtask

    // next rising edge plus the drive delay
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic run_item(input kb_t kb_v, input digest_t tag_v, input logic exp_valid,
                            input digest_t exp_key);
        logic  accepted;
        int    n_done;
        int    n;
        word_t r;
        kb       = kb_v;
        in_buf   = tag_v;
        start    = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            drive_stall();
            accepted = !stall;  // controller idle so any unstalled edge takes it
            tick();
        end
        start = 1'b0;
        while (!done) begin
            check(digest_t'(valid), '0, "valid low while busy");
            check(key, '0, "key zero while busy");
            if (noise_on) begin
                r      = rand_word();
                start  = r[0];
                kb     = rand_kb();
                in_buf = rand_tag();
            end
            drive_stall();
            tick();
        end
        start = 1'b0;
        check(digest_t'(valid), digest_t'(exp_valid), "valid at done");
        check(key, exp_key, "key at done");
        n_done = 0;
        n      = 0;
        while ((n < 6 || done) && n_done < 2) begin
            drive_stall();
            if (done && !stall) begin
                n_done++;  // this edge retires the done pulse
            end
            tick();
            n++;
            check(digest_t'(valid), digest_t'(exp_valid), "valid held after done");
            check(key, exp_key, "key held after done");
        end
        check(digest_t'(n_done), digest_t'(1), "done pulses per accepted start");
    endtask

    initial begin
        kb_t     kb_v;
        digest_t dig;
        digest_t tag;
        logic    match;
        seed     = 29;
        clk      = 1'b0;
        rst      = 1'b1;
        stall    = 1'b0;
        start    = 1'b0;
        kb       = '0;
        in_buf   = '0;
        stall_on = 1'b0;
        noise_on = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst      = 1'b0;
        stall_on = 1'b1;
        repeat (8) begin  // quiet after reset
            check(digest_t'(valid), '0, "valid low after reset");
            check(digest_t'(done), '0, "done low after reset");
            check(key, '0, "key zero after reset");
            drive_stall();
            tick();
        end
        for (int i = 0; i < NUM_ITEMS; i++) begin
            stall_on = (i >= 8);
            noise_on = (i >= 16);
            kb_v     = rand_kb();
            dig      = md5_model(kb_v);
            if (i % 2 == 0) begin
                tag = xtea_encrypt(dig, dig, XTEA_CYCLES);  // tag built to match
            end else begin
                tag = rand_tag();
            end
            match = (xtea_decrypt(tag, dig, XTEA_CYCLES) == dig);
            if (i % 2 == 0) begin
                check(digest_t'(match), digest_t'(1), "model xtea round trip");
            end
            run_item(kb_v, tag, match, match ? dig : '0);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire
